// ==== verilog/huffman_pkg.sv ====
`default_nettype none

package huffman_pkg;

  // ==============================
  // alphabet and port widths
  // ==============================
  localparam int NUM_SYMBOLS  = 6;
  localparam int SYM_W        = 8;
  localparam int CNT_W        = 8;
  localparam int CODE_W       = 8;

  // symbol k arrives as code FIRST_SYMBOL + k
  localparam int FIRST_SYMBOL = 1;

  // ==============================
  // shared types
  // ==============================
  // bit k set when symbol k is a member
  typedef logic [NUM_SYMBOLS-1:0] sym_set_t;

  typedef logic [NUM_SYMBOLS-1:0][CNT_W-1:0]  count_array_t;
  typedef logic [NUM_SYMBOLS-1:0][CODE_W-1:0] code_array_t;

endpackage

`default_nettype wire

// ==== verilog/tree_node_pkg.sv ====
`default_nettype none

package tree_node_pkg;

  import huffman_pkg::*;

  // ==============================
  // node sizing
  // ==============================
  // six 8-bit counts sum to at most 1530
  localparam int WEIGHT_W       = 11;
  localparam int NODE_ID_W      = 4;

  // leaves are ids 1..6, merged nodes 7..11
  localparam int FIRST_MERGE_ID = 7;
  localparam int NUM_MERGES     = 5;

  typedef struct packed {
    logic                 live;
    logic [WEIGHT_W-1:0]  weight;
    logic [NODE_ID_W-1:0] id;
    sym_set_t             members;
  } node_t;

  typedef node_t [NUM_SYMBOLS-1:0] node_array_t;

endpackage

`default_nettype wire

// ==== verilog/huffman_ifs.sv ====
`default_nettype none
`timescale 1ns/1ps

// ==============================
// builder <-> sorter
// ==============================
interface sort_if import tree_node_pkg::*; ();

  logic        start;
  node_array_t nodes_in;
  logic        done;
  node_array_t nodes_out;

  modport client (output start, output nodes_in, input done, input nodes_out);

  modport server (input start, input nodes_in, output done, output nodes_out);

endinterface

// ==============================
// builder -> code table
// ==============================
interface merge_if import huffman_pkg::*; ();

  logic     clear;
  logic     merge;
  // members that gain a 1 bit
  sym_set_t one_set;
  // members that gain a 0 bit
  sym_set_t zero_set;

  modport source (output clear, output merge, output one_set, output zero_set);

  modport sink (input clear, input merge, input one_set, input zero_set);

endinterface

`default_nettype wire

// ==== verilog/symbol_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

module symbol_counter import huffman_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             gray_valid,
  input  logic [SYM_W-1:0] gray_data,
  output count_array_t     counts,
  output logic             counts_valid
);

  logic gray_valid_d;
  logic burst_start;
  logic burst_end;

  // edges of the valid strobe
  assign burst_start = gray_valid & ~gray_valid_d;
  assign burst_end   = ~gray_valid & gray_valid_d;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      gray_valid_d <= 1'b0;
      counts_valid <= 1'b0;
    end else begin
      gray_valid_d <= gray_valid;
      counts_valid <= burst_end;
    end
  end

  // first sample of a burst restarts every count
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      counts <= '0;
    end else if (gray_valid) begin
      for (int k = 0; k < NUM_SYMBOLS; k++) begin
        if (gray_data == SYM_W'(FIRST_SYMBOL + k)) begin
          counts[k] <= burst_start ? CNT_W'(1) : counts[k] + 1'b1;
        end else if (burst_start) begin
          counts[k] <= '0;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/node_sorter.sv ====
`default_nettype none
`timescale 1ns/1ps

module node_sorter import huffman_pkg::*, tree_node_pkg::*; (
  input logic   clk,
  input logic   reset,
  sort_if.server sort
);

  typedef logic [$clog2(NUM_SYMBOLS)-1:0] idx_t;

  typedef enum logic [2:0] {
    S_LOAD,
    S_PASS_INIT,
    S_COMPARE,
    S_SWAP,
    S_DONE
  } state_t;

  state_t      state;
  idx_t        i;
  idx_t        j;
  idx_t        min_idx;
  node_array_t work;

  // ascending weight, larger id first on a tie, dead nodes last
  function automatic logic sorts_before(input node_t a, input node_t b);
    if (a.live != b.live) begin
      return a.live;
    end
    if (a.weight != b.weight) begin
      return a.weight < b.weight;
    end
    return a.id > b.id;
  endfunction

  // ==============================
  // selection sort FSM
  // ==============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state     <= S_LOAD;
      i         <= '0;
      j         <= '0;
      min_idx   <= '0;
      sort.done <= 1'b0;
    end else begin
      sort.done <= 1'b0;
      case (state)
        S_LOAD: begin
          if (sort.start) begin
            i     <= '0;
            state <= S_PASS_INIT;
          end
        end
        S_PASS_INIT: begin
          min_idx <= i;
          j       <= i + 1'b1;
          state   <= S_COMPARE;
        end
        S_COMPARE: begin
          // one pair per clock
          if (sorts_before(work[j], work[min_idx])) begin
            min_idx <= j;
          end
          if (j == idx_t'(NUM_SYMBOLS - 1)) begin
            state <= S_SWAP;
          end else begin
            j <= j + 1'b1;
          end
        end
        S_SWAP: begin
          if (i == idx_t'(NUM_SYMBOLS - 2)) begin
            state <= S_DONE;
          end else begin
            i     <= i + 1'b1;
            state <= S_PASS_INIT;
          end
        end
        S_DONE: begin
          sort.done <= 1'b1;
          state     <= S_LOAD;
        end
        default: state <= S_LOAD;
      endcase
    end
  end

  // working array and result
  always_ff @(posedge clk) begin
    if (state == S_LOAD && sort.start) begin
      work <= sort.nodes_in;
    end else if (state == S_SWAP) begin
      work[i]       <= work[min_idx];
      work[min_idx] <= work[i];
    end else if (state == S_DONE) begin
      sort.nodes_out <= work;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tree_builder.sv ====
`default_nettype none
`timescale 1ns/1ps

module tree_builder import huffman_pkg::*, tree_node_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  count_array_t counts,
  input  logic         counts_valid,
  sort_if.client       sort,
  merge_if.source      merge_out,
  output logic         code_valid
);

  typedef enum logic [1:0] {
    B_IDLE,
    B_SORT,
    B_DONE
  } state_t;

  state_t                            state;
  logic [$clog2(NUM_MERGES)-1:0]     merge_cnt;
  node_array_t                       nodes;
  node_t                             merged;

  assign sort.nodes_in = nodes;

  // parent of the two lightest nodes
  always_comb begin
    merged.live    = 1'b1;
    merged.weight  = sort.nodes_out[0].weight + sort.nodes_out[1].weight;
    merged.id      = NODE_ID_W'(FIRST_MERGE_ID) + NODE_ID_W'(merge_cnt);
    merged.members = sort.nodes_out[0].members | sort.nodes_out[1].members;
  end

  // ==============================
  // round control
  // ==============================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state           <= B_IDLE;
      merge_cnt       <= '0;
      code_valid      <= 1'b0;
      sort.start      <= 1'b0;
      merge_out.clear <= 1'b0;
      merge_out.merge <= 1'b0;
    end else begin
      sort.start      <= 1'b0;
      merge_out.clear <= 1'b0;
      merge_out.merge <= 1'b0;
      case (state)
        B_IDLE: begin
          if (counts_valid) begin
            code_valid      <= 1'b0;
            merge_out.clear <= 1'b1;
            sort.start      <= 1'b1;
            merge_cnt       <= '0;
            state           <= B_SORT;
          end
        end
        B_SORT: begin
          if (sort.done) begin
            merge_out.merge <= 1'b1;
            merge_cnt       <= merge_cnt + 1'b1;
            if (merge_cnt == ($bits(merge_cnt))'(NUM_MERGES - 1)) begin
              state <= B_DONE;
            end else begin
              // next round sorts the freshly merged array
              sort.start <= 1'b1;
            end
          end
        end
        B_DONE: begin
          code_valid <= 1'b1;
          state      <= B_IDLE;
        end
        default: state <= B_IDLE;
      endcase
    end
  end

  // ==============================
  // node array and merge sets
  // ==============================
  always_ff @(posedge clk) begin
    if (state == B_IDLE && counts_valid) begin
      for (int k = 0; k < NUM_SYMBOLS; k++) begin
        nodes[k] <= '{live: 1'b1,
                      weight: WEIGHT_W'(counts[k]),
                      id: NODE_ID_W'(k + 1),
                      members: sym_set_t'(1) << k};
      end
    end else if (state == B_SORT && sort.done) begin
      nodes[0] <= merged;
      nodes[1] <= '0;
      for (int k = 2; k < NUM_SYMBOLS; k++) begin
        nodes[k] <= sort.nodes_out[k];
      end
      merge_out.one_set  <= sort.nodes_out[0].members;
      merge_out.zero_set <= sort.nodes_out[1].members;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/code_table.sv ====
`default_nettype none
`timescale 1ns/1ps

module code_table import huffman_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  merge_if.sink       merge_in,
  output code_array_t hc,
  output code_array_t mask
);

  // code length so far, per symbol
  logic [NUM_SYMBOLS-1:0][$clog2(CODE_W)-1:0] len;

  // each merge adds one bit above the ones already placed
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hc   <= '0;
      mask <= '0;
      len  <= '0;
    end else if (merge_in.clear) begin
      hc   <= '0;
      mask <= '0;
      len  <= '0;
    end else if (merge_in.merge) begin
      for (int k = 0; k < NUM_SYMBOLS; k++) begin
        if (merge_in.one_set[k] || merge_in.zero_set[k]) begin
          hc[k][len[k]]   <= merge_in.one_set[k];
          mask[k][len[k]] <= 1'b1;
          len[k]          <= len[k] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/huffman_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module huffman_top import huffman_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              gray_valid,
  input  logic [SYM_W-1:0]  gray_data,
  output logic              CNT_valid,
  output logic [CNT_W-1:0]  CNT1,
  output logic [CNT_W-1:0]  CNT2,
  output logic [CNT_W-1:0]  CNT3,
  output logic [CNT_W-1:0]  CNT4,
  output logic [CNT_W-1:0]  CNT5,
  output logic [CNT_W-1:0]  CNT6,
  output logic              code_valid,
  output logic [CODE_W-1:0] HC1,
  output logic [CODE_W-1:0] HC2,
  output logic [CODE_W-1:0] HC3,
  output logic [CODE_W-1:0] HC4,
  output logic [CODE_W-1:0] HC5,
  output logic [CODE_W-1:0] HC6,
  output logic [CODE_W-1:0] M1,
  output logic [CODE_W-1:0] M2,
  output logic [CODE_W-1:0] M3,
  output logic [CODE_W-1:0] M4,
  output logic [CODE_W-1:0] M5,
  output logic [CODE_W-1:0] M6
);

  count_array_t counts;
  logic         counts_valid;
  code_array_t  hc;
  code_array_t  mask;

  sort_if  u_sort_if ();
  merge_if u_merge_if ();

  symbol_counter u_counter (
    .clk          (clk),
    .reset        (reset),
    .gray_valid   (gray_valid),
    .gray_data    (gray_data),
    .counts       (counts),
    .counts_valid (counts_valid)
  );

  node_sorter u_sorter (
    .clk   (clk),
    .reset (reset),
    .sort  (u_sort_if.server)
  );

  tree_builder u_builder (
    .clk          (clk),
    .reset        (reset),
    .counts       (counts),
    .counts_valid (counts_valid),
    .sort         (u_sort_if.client),
    .merge_out    (u_merge_if.source),
    .code_valid   (code_valid)
  );

  code_table u_table (
    .clk      (clk),
    .reset    (reset),
    .merge_in (u_merge_if.sink),
    .hc       (hc),
    .mask     (mask)
  );

  // symbol 1 sits at index 0 of each array
  assign CNT_valid = counts_valid;
  assign CNT1 = counts[0];
  assign CNT2 = counts[1];
  assign CNT3 = counts[2];
  assign CNT4 = counts[3];
  assign CNT5 = counts[4];
  assign CNT6 = counts[5];
  assign HC1  = hc[0];
  assign HC2  = hc[1];
  assign HC3  = hc[2];
  assign HC4  = hc[3];
  assign HC5  = hc[4];
  assign HC6  = hc[5];
  assign M1   = mask[0];
  assign M2   = mask[1];
  assign M3   = mask[2];
  assign M4   = mask[3];
  assign M5   = mask[4];
  assign M6   = mask[5];

endmodule

`default_nettype wire

// ==== sim/huffman_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module huffman_checker import huffman_pkg::*, tree_node_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             gray_valid,
  input  logic [SYM_W-1:0] gray_data,
  input  logic             CNT_valid,
  input  count_array_t     cnt,
  input  logic             code_valid,
  input  code_array_t      hc,
  input  code_array_t      mask,
  output int               cnt_errors,
  output int               code_errors,
  output int               ctrl_errors,
  output int               results_checked
);

  int          model_cnt [NUM_SYMBOLS];
  int          sym;
  code_array_t exp_hc;
  code_array_t exp_mask;
  code_array_t held_hc;
  code_array_t held_mask;
  logic        prev_gv;
  logic        prev_cnt_valid;
  logic        prev_code_valid;
  logic        expect_pulse;
  logic        pending;

  initial begin
    cnt_errors      = 0;
    code_errors     = 0;
    ctrl_errors     = 0;
    results_checked = 0;
    for (int k = 0; k < NUM_SYMBOLS; k++) begin
      model_cnt[k] = 0;
    end
  end

  // ascending weight, larger id first between equal weights
  function automatic bit lighter(input int wa, input int ia, input int wb, input int ib);
    return (wa < wb) || (wa == wb && ia > ib);
  endfunction

  // ==============================
  // reference tree and codes
  // ==============================
  task automatic build_model();
    int                     w [NUM_SYMBOLS];
    int                     nid [NUM_SYMBOLS];
    bit                     alive [NUM_SYMBOLS];
    logic [NUM_SYMBOLS-1:0] members [NUM_SYMBOLS];
    int                     len [NUM_SYMBOLS];
    int                     a;
    int                     b;
    exp_hc   = '0;
    exp_mask = '0;
    for (int k = 0; k < NUM_SYMBOLS; k++) begin
      w[k]       = model_cnt[k];
      nid[k]     = k + 1;
      alive[k]   = 1'b1;
      members[k] = NUM_SYMBOLS'(1) << k;
      len[k]     = 0;
    end
    for (int r = 0; r < NUM_MERGES; r++) begin
      a = -1;
      b = -1;
      // find the two lightest live nodes with a sorting first
      for (int k = 0; k < NUM_SYMBOLS; k++) begin
        if (alive[k]) begin
          if (a < 0 || lighter(w[k], nid[k], w[a], nid[a])) begin
            b = a;
            a = k;
          end else if (b < 0 || lighter(w[k], nid[k], w[b], nid[b])) begin
            b = k;
          end
        end
      end
      // members of a gain a 1, members of b a 0
      for (int s = 0; s < NUM_SYMBOLS; s++) begin
        if (members[a][s] || members[b][s]) begin
          if (members[a][s]) begin
            exp_hc[s] = exp_hc[s] | (CODE_W'(1) << len[s]);
          end
          exp_mask[s] = exp_mask[s] | (CODE_W'(1) << len[s]);
          len[s]      = len[s] + 1;
        end
      end
      w[a]       = w[a] + w[b];
      nid[a]     = FIRST_MERGE_ID + r;
      members[a] = members[a] | members[b];
      alive[b]   = 1'b0;
    end
  endtask

  task automatic check_counts();
    for (int k = 0; k < NUM_SYMBOLS; k++) begin
      if (cnt[k] !== CNT_W'(model_cnt[k])) begin
        cnt_errors++;
        $display("mismatch at %0d ns: CNT%0d is %0d, expected %0d",
                 $time, k + 1, cnt[k], model_cnt[k]);
      end
    end
  endtask

  task automatic check_codes();
    int ones;
    results_checked++;
    for (int k = 0; k < NUM_SYMBOLS; k++) begin
      if (hc[k] !== exp_hc[k] || mask[k] !== exp_mask[k]) begin
        code_errors++;
        $display("mismatch at %0d ns: HC%0d/M%0d is %b/%b, expected %b/%b",
                 $time, k + 1, k + 1, hc[k], mask[k], exp_hc[k], exp_mask[k]);
      end
      ones = 0;
      for (int n = 0; n < CODE_W; n++) begin
        ones = ones + int'(mask[k][n]);
      end
      if (ones < 1 || ones > NUM_MERGES) begin
        code_errors++;
        $display("mismatch at %0d ns: M%0d has %0d ones, expected 1 to %0d",
                 $time, k + 1, ones, NUM_MERGES);
      end
      if ((hc[k] & ~mask[k]) !== '0) begin
        code_errors++;
        $display("mismatch at %0d ns: HC%0d is %b, has bits outside M%0d",
                 $time, k + 1, hc[k], k + 1);
      end
    end
  endtask

  // ==============================
  // watch the DUT on falling edges
  // ==============================
  always @(negedge clk) begin
    if (reset) begin
      if (CNT_valid !== 1'b0 || code_valid !== 1'b0 || cnt !== '0 || hc !== '0
          || mask !== '0) begin
        ctrl_errors++;
        $display("mismatch at %0d ns: outputs not all zero during reset", $time);
      end
      prev_gv         = 1'b0;
      prev_cnt_valid  = 1'b0;
      prev_code_valid = 1'b0;
      expect_pulse    = 1'b0;
      pending         = 1'b0;
    end else begin
      if (CNT_valid !== expect_pulse) begin
        ctrl_errors++;
        $display("mismatch at %0d ns: CNT_valid is %b, expected %b",
                 $time, CNT_valid, expect_pulse);
      end
      if (CNT_valid === 1'b1) begin
        check_counts();
        build_model();
        pending = 1'b1;
      end
      if (prev_cnt_valid && code_valid !== 1'b0) begin
        ctrl_errors++;
        $display("mismatch at %0d ns: code_valid is %b one cycle after CNT_valid, expected 0",
                 $time, code_valid);
      end
      if (prev_code_valid && !code_valid && !prev_cnt_valid) begin
        ctrl_errors++;
        $display("mismatch at %0d ns: code_valid is 0 without a CNT_valid before it, expected 1",
                 $time);
      end
      if (prev_code_valid && code_valid && (hc !== held_hc || mask !== held_mask)) begin
        code_errors++;
        $display("mismatch at %0d ns: HC or M changed while code_valid was high", $time);
      end
      if (code_valid && !prev_code_valid) begin
        if (!pending) begin
          ctrl_errors++;
          $display("error at %0d ns: code_valid rose with no count result before it", $time);
        end else begin
          check_codes();
        end
        pending   = 1'b0;
        held_hc   = hc;
        held_mask = mask;
      end
      // model counts restart on the first sample of a burst
      if (gray_valid) begin
        if (!prev_gv) begin
          for (int k = 0; k < NUM_SYMBOLS; k++) begin
            model_cnt[k] = 0;
          end
        end
        sym = int'(gray_data) - FIRST_SYMBOL;
        if (sym >= 0 && sym < NUM_SYMBOLS) begin
          model_cnt[sym] = (model_cnt[sym] + 1) % (1 << CNT_W);
        end
      end
      expect_pulse    = prev_gv & ~gray_valid;
      prev_gv         = gray_valid;
      prev_cnt_valid  = CNT_valid;
      prev_code_valid = code_valid;
    end
  end

endmodule

`default_nettype wire

// ==== sim/huffman_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module huffman_tb import huffman_pkg::*; ();

  localparam int NUM_BURSTS     = 20;
  localparam int MAX_LEN        = 120;
  // longest burst plus tree building and gap for every burst
  localparam int TIMEOUT_CYCLES = NUM_BURSTS * (MAX_LEN + 400 + 10);

  logic             clk;
  logic             reset;
  logic             gray_valid;
  logic [SYM_W-1:0] gray_data;
  logic             CNT_valid;
  logic             code_valid;
  count_array_t     cnt;
  code_array_t      hc;
  code_array_t      mask;
  int               cnt_errors;
  int               code_errors;
  int               ctrl_errors;
  int               results_checked;
  int               seed;
  int               cycle_count = 0;

  huffman_top u_dut (
    .clk        (clk),
    .reset      (reset),
    .gray_valid (gray_valid),
    .gray_data  (gray_data),
    .CNT_valid  (CNT_valid),
    .CNT1       (cnt[0]),
    .CNT2       (cnt[1]),
    .CNT3       (cnt[2]),
    .CNT4       (cnt[3]),
    .CNT5       (cnt[4]),
    .CNT6       (cnt[5]),
    .code_valid (code_valid),
    .HC1        (hc[0]),
    .HC2        (hc[1]),
    .HC3        (hc[2]),
    .HC4        (hc[3]),
    .HC5        (hc[4]),
    .HC6        (hc[5]),
    .M1         (mask[0]),
    .M2         (mask[1]),
    .M3         (mask[2]),
    .M4         (mask[3]),
    .M5         (mask[4]),
    .M6         (mask[5])
  );

  huffman_checker u_checker (.*);

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run still going after %0d cycles, code_valid never came",
               TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // ==============================
  // stimulus
  // ==============================
  // mode 0/3 mixed symbols and noise, 1 one symbol, 2 equal counts
  task automatic drive_burst(input int mode);
    int len;
    int single;
    int r;
    int value;
    len    = 1 + int'($unsigned($random(seed)) % MAX_LEN);
    single = FIRST_SYMBOL + int'($unsigned($random(seed)) % NUM_SYMBOLS);
    if (mode == 2) begin
      len = NUM_SYMBOLS * (1 + int'($unsigned($random(seed)) % (MAX_LEN / NUM_SYMBOLS)));
    end
    for (int n = 0; n < len; n++) begin
      r = int'($unsigned($random(seed)) % 16);
      if (mode == 1) begin
        value = (r == 0) ? 0 : single;
      end else if (mode == 2) begin
        value = FIRST_SYMBOL + (n % NUM_SYMBOLS);
      end else if (r == 0) begin
        value = 0;
      end else if (r < 3) begin
        // codes 7..255 are not symbols
        value = 7 + int'($unsigned($random(seed)) % 249);
      end else begin
        value = FIRST_SYMBOL + (r % NUM_SYMBOLS);
      end
      @(posedge clk);
      gray_valid <= 1'b1;
      gray_data  <= SYM_W'(value);
    end
    @(posedge clk);
    gray_valid <= 1'b0;
    gray_data  <= '0;
  endtask

  // old code_valid drops first, then the new result arrives
  task automatic wait_for_codes();
    do @(negedge clk); while (code_valid);
    do @(negedge clk); while (!code_valid);
  endtask

  initial begin
    int total;
    seed       = 80326;
    clk        = 1'b0;
    reset      = 1'b1;
    gray_valid = 1'b0;
    gray_data  = '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    repeat (3) @(posedge clk);
    for (int b = 0; b < NUM_BURSTS; b++) begin
      drive_burst(b % 4);
      wait_for_codes();
      repeat (3) @(posedge clk);
    end
    repeat (2) @(posedge clk);
    if (results_checked != NUM_BURSTS) begin
      $display("error: only %0d of %0d code results were checked",
               results_checked, NUM_BURSTS);
    end
    total = cnt_errors + code_errors + ctrl_errors;
    $display("errors: counts %0d, codes %0d, control %0d",
             cnt_errors, code_errors, ctrl_errors);
    if (total == 0 && results_checked == NUM_BURSTS) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
verilog/huffman_pkg.sv
verilog/tree_node_pkg.sv
verilog/huffman_ifs.sv
verilog/symbol_counter.sv
verilog/node_sorter.sv
verilog/tree_builder.sv
verilog/code_table.sv
verilog/huffman_top.sv
sim/huffman_checker.sv
sim/huffman_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the Huffman testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --timescale 1ns/1ps \
  --top-module huffman_tb -Mdir obj_dir -f sources.f

output=$(./obj_dir/Vhuffman_tb)
echo "$output"

if echo "$output" | grep -q "^SIMULATION PASSED$"; then
  exit 0
else
  exit 1
fi
